//--- verilog/mem_bus_pkg.sv
package mem_bus_pkg;

	//////////////////////////////////////////////////
	// Bus widths
	//////////////////////////////////////////////////

	localparam int word_width = 16;
	localparam int addr_width = 16;
	localparam int tag_width = 32;

	typedef logic [word_width-1:0] word_t;
	typedef logic [addr_width-1:0] addr_t;
	typedef logic [tag_width-1:0] tag_t;

	// CPU access, held steady until done
	typedef struct packed {
		logic rd;
		logic wr;
		addr_t addr;
		word_t wdata;
		tag_t tag;
	} mem_req_t;

	// SRAM strobes, all active low
	typedef struct packed {
		logic en_n;
		logic oe_n;
		logic we_n;
	} sram_ctl_t;

	localparam sram_ctl_t sram_ctl_idle = '{en_n: 1'b1, oe_n: 1'b1, we_n: 1'b1};

endpackage

//--- verilog/uart_chip_pkg.sv
package uart_chip_pkg;

	//////////////////////////////////////////////////
	// Parallel UART chip pins
	//////////////////////////////////////////////////

	// Status lines from the chip
	typedef struct packed {
		logic data_ready;
		logic tbre;
		logic tsre;
	} uart_stat_t;

	// Read and write strobes, active low
	typedef struct packed {
		logic rdn;
		logic wrn;
	} uart_ctl_t;

	localparam uart_ctl_t uart_ctl_idle = '{rdn: 1'b1, wrn: 1'b1};

endpackage

//--- verilog/rx_queue.sv
`timescale 1ns/10ps

module rx_queue
	import mem_bus_pkg::*;
#(
	parameter int rx_depth_log2 = 2
) (
	input logic clk,
	input logic reset,
	input logic push,
	input word_t push_data,
	input logic pop,
	output word_t front_data,
	output logic empty,
	output logic full
);

	localparam int depth = 1 << rx_depth_log2;

	logic [rx_depth_log2-1:0] front_ptr;
	logic [rx_depth_log2-1:0] tail_ptr;
	logic [rx_depth_log2:0] count;
	word_t mem [depth];

	logic do_push;
	logic do_pop;

	// Requests against a full or empty queue are dropped
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	always_ff @(posedge clk) begin
		if (reset) begin
			front_ptr <= '0;
			tail_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				tail_ptr <= tail_ptr + 1'b1;
			if (do_pop)
				front_ptr <= front_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem[tail_ptr] <= push_data;
	end

	assign front_data = mem[front_ptr];
	assign empty = (count == '0);
	assign full = (count == depth[rx_depth_log2:0]);

endmodule

//--- verilog/mem_uart_ctrl.sv
`timescale 1ns/10ps

module mem_uart_ctrl
	import mem_bus_pkg::*;
	import uart_chip_pkg::*;
#(
	parameter addr_t uart_addr = 16'hBF00
) (
	input logic clk,
	input logic reset,

	// CPU side
	input mem_req_t req,
	input logic req_valid,
	output logic done,
	output word_t rdata,
	output logic err,

	// SRAM side and shared data bus
	output addr_t ram_addr,
	output sram_ctl_t ram_ctl,
	output word_t bus_out,
	output logic bus_oe,
	input word_t bus_in,

	// UART chip
	input uart_stat_t uart_stat,
	output uart_ctl_t uart_ctl,

	// Receive queue
	output logic q_push,
	output word_t q_push_data,
	output logic q_pop,
	input word_t q_front,
	input logic q_empty,
	input logic q_full
);

	// Upper nibble groups the states by device
	typedef enum logic [7:0] {
		st_idle = 8'h0f,
		st_rx1 = 8'hd1,
		st_rx2 = 8'hd2,
		st_qrd = 8'h83,
		st_tx_setup = 8'he1,
		st_tx_strobe = 8'he2,
		st_tx_tbre = 8'he3,
		st_tx_tsre = 8'he4,
		st_rd1 = 8'h51,
		st_rd2 = 8'h52,
		st_wr1 = 8'h61,
		st_wr2 = 8'h62
	} state_t;

	state_t state;

	logic done_flag;
	tag_t done_tag;

	logic is_uart;
	logic req_ok;
	logic rx_ready;
	logic accept;
	logic complete;

	//////////////////////////////////////////////////
	// Request decode and completion
	//////////////////////////////////////////////////

	assign is_uart = (req.addr == uart_addr);
	assign req_ok = req.rd ^ req.wr;

	// Word waiting at the chip and room to keep it
	assign rx_ready = uart_stat.data_ready && !q_full;

	// Receive polling wins over the CPU in idle
	assign accept = (state == st_idle) && !rx_ready && req_valid && !done;

	// Done only while the CPU still shows the completed tag
	assign done = done_flag && (req.tag == done_tag);

	always_comb begin
		case (state)
			st_idle: complete = accept && !req_ok;
			st_qrd, st_rd2, st_wr2: complete = 1'b1;
			st_tx_tsre: complete = uart_stat.tsre;
			default: complete = 1'b0;
		endcase
	end

	assign ram_addr = req.addr;
	assign bus_out = req.wdata;

	//////////////////////////////////////////////////
	// Sequencer
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			ram_ctl <= sram_ctl_idle;
			uart_ctl <= uart_ctl_idle;
			bus_oe <= 1'b0;
			done_flag <= 1'b0;
			err <= 1'b0;
			q_push <= 1'b0;
			q_pop <= 1'b0;
		end else begin
			q_push <= 1'b0;
			q_pop <= 1'b0;

			case (state)
				st_idle: begin
					if (rx_ready) begin
						uart_ctl.rdn <= 1'b0;
						state <= st_rx1;
					end else if (accept && req_ok) begin
						done_flag <= 1'b0;
						case ({is_uart, req.wr})
							2'b10: begin
								state <= st_qrd;
							end
							2'b11: begin
								bus_oe <= 1'b1;
								state <= st_tx_setup;
							end
							2'b00: begin
								ram_ctl.en_n <= 1'b0;
								state <= st_rd1;
							end
							default: begin
								ram_ctl.en_n <= 1'b0;
								bus_oe <= 1'b1;
								state <= st_wr1;
							end
						endcase
					end else if (accept) begin
						// Both or neither of rd and wr
						err <= 1'b1;
					end
				end

				// Pull one word from the chip
				st_rx1: begin
					q_push <= 1'b1;
					state <= st_rx2;
				end
				st_rx2: begin
					uart_ctl.rdn <= 1'b1;
					state <= st_idle;
				end

				// Nothing popped from an empty queue
				st_qrd: begin
					q_pop <= !q_empty;
					state <= st_idle;
				end

				st_tx_setup: begin
					uart_ctl.wrn <= 1'b0;
					state <= st_tx_strobe;
				end
				st_tx_strobe: begin
					if (!uart_stat.tbre) begin
						uart_ctl.wrn <= 1'b1;
						state <= st_tx_tbre;
					end
				end
				st_tx_tbre: begin
					if (uart_stat.tbre)
						state <= st_tx_tsre;
				end
				st_tx_tsre: begin
					if (uart_stat.tsre) begin
						bus_oe <= 1'b0;
						state <= st_idle;
					end
				end

				st_rd1: begin
					ram_ctl.oe_n <= 1'b0;
					state <= st_rd2;
				end
				st_rd2: begin
					ram_ctl <= sram_ctl_idle;
					state <= st_idle;
				end

				st_wr1: begin
					ram_ctl.we_n <= 1'b0;
					state <= st_wr2;
				end
				st_wr2: begin
					ram_ctl <= sram_ctl_idle;
					bus_oe <= 1'b0;
					state <= st_idle;
				end

				default: begin
					ram_ctl <= sram_ctl_idle;
					uart_ctl <= uart_ctl_idle;
					bus_oe <= 1'b0;
					state <= st_idle;
				end
			endcase

			if (complete)
				done_flag <= 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Data capture
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (state == st_rx1)
			q_push_data <= bus_in;

		if (state == st_rd2)
			rdata <= bus_in;
		else if (state == st_qrd)
			rdata <= q_empty ? '0 : q_front;

		if (complete)
			done_tag <= req.tag;
	end

endmodule

//--- verilog/mem_uart_top.sv
`timescale 1ns/10ps

module mem_uart_top
	import mem_bus_pkg::*;
	import uart_chip_pkg::*;
#(
	parameter addr_t uart_addr = 16'hBF00,
	parameter int rx_depth_log2 = 2
) (
	input logic clk,
	input logic reset,

	// CPU side
	input mem_req_t req,
	input logic req_valid,
	output logic done,
	output word_t rdata,
	output logic err,

	// SRAM and shared bus
	output addr_t ram_addr,
	output sram_ctl_t ram_ctl,
	output word_t bus_out,
	output logic bus_oe,
	input word_t bus_in,

	// UART chip
	input uart_stat_t uart_stat,
	output uart_ctl_t uart_ctl
);

	logic q_push;
	word_t q_push_data;
	logic q_pop;
	word_t q_front;
	logic q_empty;
	logic q_full;

	mem_uart_ctrl #(
		.uart_addr(uart_addr)
	) mem_uart_ctrl_inst (
		.clk(clk),
		.reset(reset),
		.req(req),
		.req_valid(req_valid),
		.done(done),
		.rdata(rdata),
		.err(err),
		.ram_addr(ram_addr),
		.ram_ctl(ram_ctl),
		.bus_out(bus_out),
		.bus_oe(bus_oe),
		.bus_in(bus_in),
		.uart_stat(uart_stat),
		.uart_ctl(uart_ctl),
		.q_push(q_push),
		.q_push_data(q_push_data),
		.q_pop(q_pop),
		.q_front(q_front),
		.q_empty(q_empty),
		.q_full(q_full)
	);

	rx_queue #(
		.rx_depth_log2(rx_depth_log2)
	) rx_queue_inst (
		.clk(clk),
		.reset(reset),
		.push(q_push),
		.push_data(q_push_data),
		.pop(q_pop),
		.front_data(q_front),
		.empty(q_empty),
		.full(q_full)
	);

endmodule

//--- test/sram_model.sv
`timescale 1ns/10ps

module sram_model
	import mem_bus_pkg::*;
(
	input logic clk,
	input addr_t addr,
	input sram_ctl_t ctl,
	input word_t bus,
	output word_t data,
	output logic drive
);

	word_t mem [0:65535];

	// Stored word goes out while enabled and output enabled
	assign drive = !ctl.en_n && !ctl.oe_n && ctl.we_n;
	assign data = mem[addr];

	// we_n is low for a whole clock, sampled mid-cycle
	always @(negedge clk) begin
		if (!ctl.en_n && !ctl.we_n)
			mem[addr] <= bus;
	end

endmodule

//--- test/uart_chip_model.sv
`timescale 1ns/10ps

module uart_chip_model
	import mem_bus_pkg::*;
	import uart_chip_pkg::*;
(
	input logic clk,
	input logic reset,
	input uart_ctl_t ctl,
	output uart_stat_t stat,
	input word_t bus,
	output word_t data,
	output logic drive,
	input logic inject,
	input word_t inject_data,
	output logic tx_valid,
	output word_t tx_data
);

	word_t rx_fifo [$];
	word_t rx_hold;
	logic rx_taken;
	logic data_ready;
	logic wrn_q;
	int tx_count;

	// Transmit buffer empties first, shift register later
	assign stat = '{data_ready: data_ready, tbre: (tx_count <= 3), tsre: (tx_count <= 1)};
	assign drive = !ctl.rdn;
	assign data = rx_hold;

	always @(negedge clk) begin
		if (reset) begin
			rx_fifo.delete();
			rx_taken <= 1'b0;
			data_ready <= 1'b0;
			wrn_q <= 1'b1;
			tx_count <= 0;
			tx_valid <= 1'b0;
		end else begin
			if (inject)
				rx_fifo.push_back(inject_data);

			// One word per rdn strobe
			if (!ctl.rdn && !rx_taken && rx_fifo.size() != 0) begin
				rx_hold <= rx_fifo[0];
				rx_fifo.delete(0);
				rx_taken <= 1'b1;
			end else if (ctl.rdn) begin
				rx_taken <= 1'b0;
			end
			data_ready <= (rx_fifo.size() != 0);

			// Capture on the rising edge of wrn
			wrn_q <= ctl.wrn;
			tx_valid <= ctl.wrn && !wrn_q;
			if (ctl.wrn && !wrn_q)
				tx_data <= bus;

			if (!ctl.wrn && tx_count == 0)
				tx_count <= 6;
			else if (tx_count != 0)
				tx_count <= tx_count - 1;
		end
	end

endmodule

//--- test/tb_mem_uart.sv
`timescale 1ns/10ps

module tb_mem_uart
	import mem_bus_pkg::*;
	import uart_chip_pkg::*;
();

	localparam addr_t uart_addr = 16'hBF00;
	localparam int rx_depth_log2 = 2;
	localparam int n_ram = 8;
	localparam int n_tx = 4;
	localparam int n_rx = 6;
	localparam int n_access = 4 * n_ram + n_tx + n_rx + 3;

	logic clk;
	logic reset;
	mem_req_t req;
	logic req_valid;
	logic done;
	word_t rdata;
	logic err;
	addr_t ram_addr;
	sram_ctl_t ram_ctl;
	word_t bus_out;
	logic bus_oe;
	word_t bus_in;
	uart_stat_t uart_stat;
	uart_ctl_t uart_ctl;
	word_t ram_data;
	logic ram_drive;
	word_t uart_data;
	logic uart_drive;
	logic inject;
	word_t inject_data;
	logic tx_valid;
	word_t tx_data;

	logic [31:0] lfsr;
	tag_t tag;
	int errors;
	word_t ram_copy [addr_t];
	word_t tx_expect [$];
	word_t rx_words [n_rx];

	mem_uart_top #(
		.uart_addr(uart_addr),
		.rx_depth_log2(rx_depth_log2)
	) mem_uart_top_inst (.*);

	sram_model sram_model_inst (
		.clk(clk),
		.addr(ram_addr),
		.ctl(ram_ctl),
		.bus(bus_in),
		.data(ram_data),
		.drive(ram_drive)
	);

	uart_chip_model uart_chip_model_inst (
		.clk(clk),
		.reset(reset),
		.ctl(uart_ctl),
		.stat(uart_stat),
		.bus(bus_in),
		.data(uart_data),
		.drive(uart_drive),
		.inject(inject),
		.inject_data(inject_data),
		.tx_valid(tx_valid),
		.tx_data(tx_data)
	);

	// Shared data bus
	assign bus_in = bus_oe ? bus_out : (uart_drive ? uart_data : (ram_drive ? ram_data : '0));

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	function automatic word_t take_bits(int n);
		word_t v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			v = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic count_error(input string msg);
		$display("Error at time %0t: %s", $time, msg);
		errors++;
	endtask

	// New tag starts the access and done ends it
	task automatic access(input logic rd, input logic wr, input addr_t addr, input word_t wdata,
			output word_t data, output int cycles);
		tag = tag + 1'b1;
		req = '{rd: rd, wr: wr, addr: addr, wdata: wdata, tag: tag};
		req_valid = 1'b1;
		cycles = 0;
		do begin
			@(posedge clk);
			#5;
			cycles++;
		end while (!done);
		req_valid = 1'b0;
		data = rdata;
	endtask

	task automatic ram_round_trip(input int n);
		addr_t addrs [$];
		addr_t a;
		word_t w;
		word_t got;
		int cycles;
		for (int i = 0; i < n; i++) begin
			a = take_bits(16);
			if (a == uart_addr)
				a = ~a;
			w = take_bits(16);
			addrs.push_back(a);
			ram_copy[a] = w;
			access(1'b0, 1'b1, a, w, got, cycles);
			assert (cycles == 3)
				else count_error($sformatf("RAM write done after %0d cycles", cycles));
		end
		foreach (addrs[i]) begin
			access(1'b1, 1'b0, addrs[i], '0, got, cycles);
			assert (got == ram_copy[addrs[i]] && cycles == 3)
				else count_error($sformatf("RAM %h read %h after %0d cycles, expected %h",
					addrs[i], got, cycles, ram_copy[addrs[i]]));
		end
	endtask

	//////////////////////////////////////////////////
	// Protocol checks
	//////////////////////////////////////////////////

	assert property (@(posedge clk) disable iff (reset) req.tag != $past(req.tag) |-> !done)
		else count_error("done high in the cycle after a tag change");

	assert property (@(posedge clk) disable iff (reset)
			$past(done) && req.tag == $past(req.tag) |-> done)
		else count_error("done dropped while the tag was held");

	assert property (@(posedge clk) disable iff (reset)
			!(bus_oe && (!uart_ctl.rdn || !ram_ctl.oe_n)))
		else count_error("bus driven by the DUT and a device at once");

	// Invalid requests move no strobe
	assert property (@(posedge clk) disable iff (reset) req_valid && req.rd && req.wr |=>
			ram_ctl == sram_ctl_idle && uart_ctl == uart_ctl_idle && !bus_oe)
		else count_error("strobe activity on an invalid request");

	always @(posedge clk) begin
		if (tx_valid) begin
			assert (tx_expect.size() != 0 && tx_data == tx_expect[0])
				else count_error($sformatf("chip captured %h out of order", tx_data));
			if (tx_expect.size() != 0)
				tx_expect.delete(0);
		end
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	initial begin
		word_t got;
		word_t w;
		int cycles;
		lfsr = 32'h33c2_f6c7;
		errors = 0;
		tag = '0;
		reset = 1'b1;
		req = '0;
		req_valid = 1'b0;
		inject = 1'b0;
		inject_data = '0;
		repeat (10) @(posedge clk);
		#5;
		reset = 1'b0;

		assert (ram_ctl == sram_ctl_idle && uart_ctl == uart_ctl_idle && !bus_oe && !done && !err)
			else count_error("outputs not idle after reset");
		access(1'b1, 1'b0, uart_addr, '0, got, cycles);
		assert (got == 16'h0000 && cycles == 2)
			else count_error($sformatf("idle UART read gave %h after %0d cycles", got, cycles));

		ram_round_trip(n_ram);

		for (int i = 0; i < n_tx; i++) begin
			w = take_bits(16);
			tx_expect.push_back(w);
			access(1'b0, 1'b1, uart_addr, w, got, cycles);
		end
		assert (tx_expect.size() == 0)
			else count_error($sformatf("%0d transmitted words never captured", tx_expect.size()));

		// Six words against a four word queue
		for (int i = 0; i < n_rx; i++) begin
			rx_words[i] = take_bits(16);
			inject = 1'b1;
			inject_data = rx_words[i];
			@(posedge clk);
			#5;
		end
		inject = 1'b0;
		for (int i = 0; i <= n_rx; i++) begin
			w = (i < n_rx) ? rx_words[i] : 16'h0000;
			access(1'b1, 1'b0, uart_addr, '0, got, cycles);
			assert (got == w)
				else count_error($sformatf("UART read %0d gave %h, expected %h", i, got, w));
		end

		assert (!err) else count_error("err set before any invalid request");
		access(1'b1, 1'b1, take_bits(16), '0, got, cycles);
		assert (err && cycles == 1)
			else count_error($sformatf("invalid request: err %b after %0d cycles", err, cycles));
		ram_round_trip(n_ram);
		assert (err) else count_error("err cleared without reset");

		$display("Run complete, %0d accesses, %0d errors", n_access, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	initial begin
		repeat (n_access * 40 + 200) @(posedge clk);
		$display("Timeout: the run did not finish in %0d cycles, %0d errors so far",
			n_access * 40 + 200, errors);
		$display("tests failed");
		$finish;
	end

endmodule

//--- sim.f
verilog/mem_bus_pkg.sv
verilog/uart_chip_pkg.sv
verilog/rx_queue.sv
verilog/mem_uart_ctrl.sv
verilog/mem_uart_top.sv
test/sram_model.sv
test/uart_chip_model.sv
test/tb_mem_uart.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the memory and UART bus testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/10ps -j 0 \
	--top-module tb_mem_uart -Mdir obj_dir -f sim.f

./obj_dir/Vtb_mem_uart | tee sim.log

if grep -q "tests failed" sim.log; then
	echo "Simulation FAILED, see sim.log"
	exit 1
fi

echo "Simulation finished without failures"
